// ==== Makefile ====
# Verilator build and run of the register file testbench

VERILATOR ?= verilator
TOP ?= prf_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh)
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

# the simulator exits non-zero when the testbench fails
test: $(SIM)
	./$(SIM)

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== common/prf_defs.svh ====
// register file sizing macros: register, bank and requester counts, data and ROB widths
`ifndef PRF_DEFS_SVH
`define PRF_DEFS_SVH

// ------------------------------
// physical registers
`define PRF_PR_COUNT 32
`define PRF_LOG_PR_COUNT 5

// banking, bank = low bits of register number
`define PRF_BANK_COUNT 4
`define PRF_LOG_BANK_COUNT 2

// ------------------------------
// requesters
`define PRF_RR_COUNT 4
`define PRF_WR_COUNT 3

// ------------------------------
// payload widths
`define PRF_DATA_WIDTH 32
`define PRF_ROB_WIDTH 4

`endif

// ==== common/prf_pkg.sv ====
// register file types: read request/response, writeback request, writeback and complete buses
`default_nettype none

`include "prf_defs.svh"

package prf_pkg;

	// ------------------------------
	// read side

	// one read request per requester per cycle
	typedef struct packed {
		logic valid;
		logic [`PRF_LOG_PR_COUNT-1:0] pr;
	} read_req_t;

	// port tells which word of the bank's read data to take
	typedef struct packed {
		logic ack;
		logic port;
	} read_resp_t;

	// ------------------------------
	// writeback side
	typedef struct packed {
		logic valid;
		logic send_complete;
		logic [`PRF_DATA_WIDTH-1:0] data;
		logic [`PRF_LOG_PR_COUNT-1:0] pr;
		logic [`PRF_ROB_WIDTH-1:0] rob_index;
	} wb_req_t;

	// bank is implied by bus position, only upper bits travel
	typedef struct packed {
		logic valid;
		logic [`PRF_LOG_PR_COUNT-`PRF_LOG_BANK_COUNT-1:0] upper_pr;
	} wb_bus_t;

	typedef struct packed {
		logic valid;
		logic [`PRF_ROB_WIDTH-1:0] rob_index;
	} complete_bus_t;

endpackage

`default_nettype wire

// ==== hdl/prf_wrapper.sv ====
// top level: input and output flops around the register file core
`timescale 1ns/1ps
`default_nettype none

`include "prf_defs.svh"

module prf_wrapper (
	input logic CLK,
	input logic nRST,

	// requests, captured on the next edge
	input prf_pkg::read_req_t [`PRF_RR_COUNT-1:0] next_read_req,
	input prf_pkg::wb_req_t [`PRF_WR_COUNT-1:0] next_wb_req,

	// read response by requester, data by bank and port
	output prf_pkg::read_resp_t [`PRF_RR_COUNT-1:0] last_read_resp,
	output logic [`PRF_BANK_COUNT-1:0][1:0][`PRF_DATA_WIDTH-1:0] last_read_data,

	// writeback feedback and buses
	output logic [`PRF_WR_COUNT-1:0] last_wb_ready,
	output prf_pkg::wb_bus_t [`PRF_BANK_COUNT-1:0] last_wb_bus,
	output logic [`PRF_BANK_COUNT-1:0][`PRF_DATA_WIDTH-1:0] last_forward_data,
	output prf_pkg::complete_bus_t [`PRF_BANK_COUNT-1:0] last_complete_bus
);

	// ------------------------------
	// core side signals
	prf_pkg::read_req_t [`PRF_RR_COUNT-1:0] read_req;
	prf_pkg::read_resp_t [`PRF_RR_COUNT-1:0] read_resp;
	logic [`PRF_BANK_COUNT-1:0][1:0][`PRF_DATA_WIDTH-1:0] read_data;
	prf_pkg::wb_req_t [`PRF_WR_COUNT-1:0] wb_req;
	logic [`PRF_WR_COUNT-1:0] wb_ready;
	prf_pkg::wb_bus_t [`PRF_BANK_COUNT-1:0] wb_bus;
	logic [`PRF_BANK_COUNT-1:0][`PRF_DATA_WIDTH-1:0] forward_data;
	prf_pkg::complete_bus_t [`PRF_BANK_COUNT-1:0] complete_bus;

	prf u_prf (
		.CLK(CLK),
		.nRST(nRST),
		.read_req(read_req),
		.read_resp(read_resp),
		.read_data(read_data),
		.wb_req(wb_req),
		.wb_ready(wb_ready),
		.wb_bus(wb_bus),
		.forward_data(forward_data),
		.complete_bus(complete_bus)
	);

	// ------------------------------
	// boundary flops
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			// inputs
			read_req <= '0;
			wb_req <= '0;
			// outputs
			last_read_resp <= '0;
			last_read_data <= '0;
			last_wb_ready <= '0;
			last_wb_bus <= '0;
			last_forward_data <= '0;
			last_complete_bus <= '0;
		end else begin
			read_req <= next_read_req;
			wb_req <= next_wb_req;
			// read data lands one cycle behind its ack
			last_read_resp <= read_resp;
			last_read_data <= read_data;
			last_wb_ready <= wb_ready;
			last_wb_bus <= wb_bus;
			last_forward_data <= forward_data;
			last_complete_bus <= complete_bus;
		end
	end

endmodule

`default_nettype wire

// ==== prf/prf.sv ====
// register file core: read and writeback arbiters, four banks, writeback/forward/complete buses
`timescale 1ns/1ps
`default_nettype none

`include "prf_defs.svh"

module prf (
	input logic CLK,
	input logic nRST,

	// read side
	input prf_pkg::read_req_t [`PRF_RR_COUNT-1:0] read_req,
	output prf_pkg::read_resp_t [`PRF_RR_COUNT-1:0] read_resp,
	output logic [`PRF_BANK_COUNT-1:0][1:0][`PRF_DATA_WIDTH-1:0] read_data,

	// writeback side
	input prf_pkg::wb_req_t [`PRF_WR_COUNT-1:0] wb_req,
	output logic [`PRF_WR_COUNT-1:0] wb_ready,

	// buses by bank
	output prf_pkg::wb_bus_t [`PRF_BANK_COUNT-1:0] wb_bus,
	output logic [`PRF_BANK_COUNT-1:0][`PRF_DATA_WIDTH-1:0] forward_data,
	output prf_pkg::complete_bus_t [`PRF_BANK_COUNT-1:0] complete_bus
);

	localparam int LB = `PRF_LOG_BANK_COUNT;
	localparam int LPR = `PRF_LOG_PR_COUNT;

	logic [`PRF_BANK_COUNT-1:0][1:0] bank_rd_en;
	logic [`PRF_BANK_COUNT-1:0][1:0][LPR-LB-1:0] bank_rd_pr;
	logic [`PRF_BANK_COUNT-1:0][`PRF_WR_COUNT-1:0] grant;

	// winning writeback request per bank, all zero if none
	prf_pkg::wb_req_t [`PRF_BANK_COUNT-1:0] bank_wb;

	// ------------------------------
	// arbiters
	prf_read_arbiter u_read_arb (
		.read_req(read_req),
		.read_resp(read_resp),
		.bank_rd_en(bank_rd_en),
		.bank_rd_pr(bank_rd_pr)
	);

	prf_wb_arbiter u_wb_arb (
		.CLK(CLK),
		.nRST(nRST),
		.wb_req(wb_req),
		.grant(grant),
		.wb_ready(wb_ready)
	);

	// one-hot grant, so an or-mux picks the winner
	always_comb begin
		bank_wb = '0;
		for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
			for (int wr = 0; wr < `PRF_WR_COUNT; wr++) begin
				if (grant[b][wr]) begin
					bank_wb[b] = bank_wb[b] | wb_req[wr];
				end
			end
		end
	end

	// ------------------------------
	// banks and buses
	for (genvar b = 0; b < `PRF_BANK_COUNT; b++) begin : g_bank
		prf_bank #(
			.BANK_ID(b)
		) u_bank (
			.CLK(CLK),
			.nRST(nRST),
			.rd_en(bank_rd_en[b]),
			.rd_pr(bank_rd_pr[b]),
			.rd_data(read_data[b]),
			.wr_en(bank_wb[b].valid),
			.wr_pr(bank_wb[b].pr[LPR-1:LB]),
			.wr_data(bank_wb[b].data)
		);

		// bus position gives the bank, upper bits finish the register number
		assign wb_bus[b].valid = bank_wb[b].valid;
		assign wb_bus[b].upper_pr = bank_wb[b].pr[LPR-1:LB];
		// same-cycle readers pick the new value up here
		assign forward_data[b] = bank_wb[b].data;
		// completion only when the writer asked for it
		assign complete_bus[b].valid = bank_wb[b].valid & bank_wb[b].send_complete;
		assign complete_bus[b].rob_index = bank_wb[b].rob_index;
	end

endmodule

`default_nettype wire

// ==== prf/prf_bank.sv ====
// one register file bank: eight words, two registered read ports, one write port
`timescale 1ns/1ps
`default_nettype none

`include "prf_defs.svh"

module prf_bank #(
	parameter int BANK_ID = 0
) (
	input logic CLK,
	input logic nRST,

	// read ports, data valid one cycle after enable
	input logic [1:0] rd_en,
	input logic [1:0][`PRF_LOG_PR_COUNT-`PRF_LOG_BANK_COUNT-1:0] rd_pr,
	output logic [1:0][`PRF_DATA_WIDTH-1:0] rd_data,

	// write port
	input logic wr_en,
	input logic [`PRF_LOG_PR_COUNT-`PRF_LOG_BANK_COUNT-1:0] wr_pr,
	input logic [`PRF_DATA_WIDTH-1:0] wr_data
);

	localparam int WORDS = `PRF_PR_COUNT / `PRF_BANK_COUNT;

	logic [`PRF_DATA_WIDTH-1:0] mem [WORDS];
	logic wr_allow;

	// physical register 0 lives in bank 0 at upper index 0
	// cleared on reset and never written, so it always reads zero
	assign wr_allow = wr_en && !(BANK_ID == 0 && wr_pr == '0);

	// ------------------------------
	// storage and read registers
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			for (int i = 0; i < WORDS; i++) begin
				mem[i] <= '0;
			end
			rd_data <= '0;
		end else begin
			if (wr_allow) begin
				mem[wr_pr] <= wr_data;
			end
			// same-edge write not visible, reader sees old value
			for (int p = 0; p < 2; p++) begin
				if (rd_en[p]) begin
					rd_data[p] <= mem[rd_pr[p]];
				end
			end
		end
	end

	// arbiter must hand over a clean address with every enable
	for (genvar p = 0; p < 2; p++) begin : g_rd_chk
		a_rd_addr_known: assert property (@(posedge CLK) disable iff (!nRST)
			rd_en[p] |-> !$isunknown(rd_pr[p]));
	end

endmodule

`default_nettype wire

// ==== prf/prf_read_arbiter.sv ====
// read port arbiter: up to two read requesters per bank, lowest requester index first
`timescale 1ns/1ps
`default_nettype none

`include "prf_defs.svh"

module prf_read_arbiter (
	// requests and responses by read requester
	input prf_pkg::read_req_t [`PRF_RR_COUNT-1:0] read_req,
	output prf_pkg::read_resp_t [`PRF_RR_COUNT-1:0] read_resp,

	// per bank, per port enable and upper register number
	output logic [`PRF_BANK_COUNT-1:0][1:0] bank_rd_en,
	output logic [`PRF_BANK_COUNT-1:0][1:0][`PRF_LOG_PR_COUNT-`PRF_LOG_BANK_COUNT-1:0] bank_rd_pr
);

	localparam int LB = `PRF_LOG_BANK_COUNT;
	localparam int LPR = `PRF_LOG_PR_COUNT;

	// ------------------------------
	// grant in requester order
	always_comb begin
		logic [LB-1:0] bank;
		read_resp = '0;
		bank_rd_en = '0;
		bank_rd_pr = '0;
		for (int rr = 0; rr < `PRF_RR_COUNT; rr++) begin
			bank = read_req[rr].pr[LB-1:0];
			if (read_req[rr].valid) begin
				// port 0 first, then port 1
				if (!bank_rd_en[bank][0]) begin
					bank_rd_en[bank][0] = 1'b1;
					bank_rd_pr[bank][0] = read_req[rr].pr[LPR-1:LB];
					read_resp[rr].ack = 1'b1;
					read_resp[rr].port = 1'b0;
				end else if (!bank_rd_en[bank][1]) begin
					bank_rd_en[bank][1] = 1'b1;
					bank_rd_pr[bank][1] = read_req[rr].pr[LPR-1:LB];
					read_resp[rr].ack = 1'b1;
					read_resp[rr].port = 1'b1;
				end
				// both ports taken: no ack, requester retries
			end
		end
	end

	// ------------------------------
	// grant sanity, no clock in this block
	always_comb begin
		for (int rr = 0; rr < `PRF_RR_COUNT; rr++) begin
			a_ack_has_req: assert (!read_resp[rr].ack || read_req[rr].valid)
				else $error("read ack without request");
		end
		for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
			a_port_order: assert (!bank_rd_en[b][1] || bank_rd_en[b][0])
				else $error("read port 1 granted with port 0 free");
		end
	end

endmodule

`default_nettype wire

// ==== prf/prf_wb_arbiter.sv ====
// writeback arbiter: per bank round-robin grant of the single write port
`timescale 1ns/1ps
`default_nettype none

`include "prf_defs.svh"

module prf_wb_arbiter (
	input logic CLK,
	input logic nRST,

	// writeback requests by write requester
	input prf_pkg::wb_req_t [`PRF_WR_COUNT-1:0] wb_req,

	// one-hot per bank, and ready back to each requester
	output logic [`PRF_BANK_COUNT-1:0][`PRF_WR_COUNT-1:0] grant,
	output logic [`PRF_WR_COUNT-1:0] wb_ready
);

	localparam int LB = `PRF_LOG_BANK_COUNT;
	localparam int WR = `PRF_WR_COUNT;
	localparam int PTR_W = $clog2(WR);

	// next requester to favor, per bank
	logic [`PRF_BANK_COUNT-1:0][PTR_W-1:0] ptr;
	logic [`PRF_BANK_COUNT-1:0][PTR_W-1:0] win_idx;
	logic [`PRF_BANK_COUNT-1:0] win_valid;

	// ------------------------------
	// circular search from pointer
	always_comb begin
		int idx;
		grant = '0;
		win_idx = '0;
		win_valid = '0;
		for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
			for (int k = 0; k < WR; k++) begin
				// wrap pointer + offset
				idx = int'(ptr[b]) + k;
				if (idx >= WR) begin
					idx = idx - WR;
				end
				if (!win_valid[b] && wb_req[idx].valid
					&& wb_req[idx].pr[LB-1:0] == LB'(b)) begin
					win_valid[b] = 1'b1;
					win_idx[b] = PTR_W'(idx);
					grant[b][idx] = 1'b1;
				end
			end
		end
	end

	// a requester targets one bank, so at most one grant per requester
	always_comb begin
		wb_ready = '0;
		for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
			wb_ready = wb_ready | grant[b];
		end
	end

	// ------------------------------
	// pointer moves past the winner only
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			ptr <= '0;
		end else begin
			for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
				if (win_valid[b]) begin
					ptr[b] <= (win_idx[b] == PTR_W'(WR - 1)) ? '0 : win_idx[b] + 1'b1;
				end
			end
		end
	end

	for (genvar b = 0; b < `PRF_BANK_COUNT; b++) begin : g_grant_chk
		a_grant_onehot: assert property (@(posedge CLK) disable iff (!nRST)
			$onehot0(grant[b]));
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+common
common/prf_pkg.sv
prf/prf_bank.sv
prf/prf_read_arbiter.sv
prf/prf_wb_arbiter.sv
prf/prf.sv
hdl/prf_wrapper.sv
tests/prf_tb.sv

// ==== tests/prf_tb.sv ====
// register file testbench: directed step table, register and round-robin models, random phase
`timescale 1ns/1ps
`default_nettype none

`include "prf_defs.svh"

module prf_tb;

	localparam int RR = `PRF_RR_COUNT;
	localparam int WR = `PRF_WR_COUNT;
	localparam int NB = `PRF_BANK_COUNT;
	localparam int DW = `PRF_DATA_WIDTH;
	localparam int LB = `PRF_LOG_BANK_COUNT;
	localparam int LPR = `PRF_LOG_PR_COUNT;
	localparam int ROBW = `PRF_ROB_WIDTH;
	localparam int RAND_STEPS = 200;
	localparam int MAX_STEPS = 512;

	localparam prf_pkg::read_req_t NO_RD = '0;
	localparam prf_pkg::wb_req_t NO_WB = '0;
	localparam prf_pkg::read_req_t [RR-1:0] NO_READS = '0;
	localparam prf_pkg::wb_req_t [WR-1:0] NO_WRITES = '0;

	logic CLK;
	logic nRST;
	prf_pkg::read_req_t [RR-1:0] next_read_req;
	prf_pkg::wb_req_t [WR-1:0] next_wb_req;
	prf_pkg::read_resp_t [RR-1:0] last_read_resp;
	logic [NB-1:0][1:0][DW-1:0] last_read_data;
	logic [WR-1:0] last_wb_ready;
	prf_pkg::wb_bus_t [NB-1:0] last_wb_bus;
	logic [NB-1:0][DW-1:0] last_forward_data;
	prf_pkg::complete_bus_t [NB-1:0] last_complete_bus;

	// ------------------------------
	// directed table, one entry per step
	string tbl_name[$];
	prf_pkg::read_req_t [RR-1:0] tbl_rd[$];
	prf_pkg::wb_req_t [WR-1:0] tbl_wb[$];
	logic [RR-1:0] tbl_ack[$];
	logic [RR-1:0] tbl_port[$];
	logic [WR-1:0] tbl_rdy[$];

	// expectations by step number
	string step_name [MAX_STEPS];
	prf_pkg::read_req_t [RR-1:0] step_rd [MAX_STEPS];
	logic [RR-1:0] exp_ack [MAX_STEPS];
	logic [RR-1:0] exp_port [MAX_STEPS];
	logic [RR-1:0][DW-1:0] exp_data [MAX_STEPS];
	logic [WR-1:0] exp_rdy [MAX_STEPS];
	prf_pkg::wb_bus_t [NB-1:0] exp_wb_bus [MAX_STEPS];
	logic [NB-1:0][DW-1:0] exp_fwd [MAX_STEPS];
	prf_pkg::complete_bus_t [NB-1:0] exp_cmp [MAX_STEPS];

	// models: register contents and round-robin pointers
	logic [DW-1:0] model_reg [`PRF_PR_COUNT];
	int rr_ptr [NB];
	integer seed;
	int total_steps;
	int limit_cycles = 0;

	prf_wrapper dut (
		.CLK(CLK),
		.nRST(nRST),
		.next_read_req(next_read_req),
		.next_wb_req(next_wb_req),
		.last_read_resp(last_read_resp),
		.last_read_data(last_read_data),
		.last_wb_ready(last_wb_ready),
		.last_wb_bus(last_wb_bus),
		.last_forward_data(last_forward_data),
		.last_complete_bus(last_complete_bus)
	);

	always #5 CLK = ~CLK;

	task automatic compare_value(input string name, input string what,
			input logic [63:0] expected, input logic [63:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s %s expected %0h actual %0h", name, what, expected, actual);
			$display("TB FAILED");
			$fatal(1, "value mismatch on %s", what);
		end
	endtask

	function automatic prf_pkg::read_req_t make_read(input int pr);
		prf_pkg::read_req_t r;
		r.valid = 1'b1;
		r.pr = LPR'(pr);
		return r;
	endfunction

	function automatic prf_pkg::wb_req_t make_write(input int pr, input logic [DW-1:0] data,
			input int rob, input logic cmp);
		prf_pkg::wb_req_t w;
		w.valid = 1'b1;
		w.send_complete = cmp;
		w.data = data;
		w.pr = LPR'(pr);
		w.rob_index = ROBW'(rob);
		return w;
	endfunction

	task automatic add_step(input string name, input prf_pkg::read_req_t [RR-1:0] rd,
			input prf_pkg::wb_req_t [WR-1:0] wb, input logic [RR-1:0] ack,
			input logic [RR-1:0] port, input logic [WR-1:0] rdy);
		tbl_name.push_back(name);
		tbl_rd.push_back(rd);
		tbl_wb.push_back(wb);
		tbl_ack.push_back(ack);
		tbl_port.push_back(port);
		tbl_rdy.push_back(rdy);
	endtask

	// ------------------------------
	// directed steps
	task automatic build_table();
		// every register reads zero after reset, one register per bank per step
		for (int k = 0; k < 8; k++) begin
			add_step($sformatf("reset_read_%0d", k), {make_read(4 * k + 3), make_read(4 * k + 2),
				make_read(4 * k + 1), make_read(4 * k)}, NO_WRITES, 4'b1111, 4'b0000, 3'b000);
		end
		// write then read back one cycle later
		add_step("write_r5", NO_READS, {NO_WB, NO_WB, make_write(5, 32'ha5a5_0005, 3, 1'b1)},
			4'b0000, 4'b0000, 3'b001);
		add_step("write_r10", NO_READS, {NO_WB, make_write(10, 32'h1234_000a, 7, 1'b0), NO_WB},
			4'b0000, 4'b0000, 3'b010);
		add_step("read_back", {NO_RD, NO_RD, make_read(10), make_read(5)}, NO_WRITES,
			4'b0011, 4'b0000, 3'b000);
		// three readers on bank 1, third one refused
		add_step("read_one_bank", {make_read(2), make_read(13), make_read(9), make_read(5)},
			NO_WRITES, 4'b1011, 4'b0010, 3'b000);
		add_step("read_all_banks", {make_read(7), make_read(6), make_read(5), make_read(4)},
			NO_WRITES, 4'b1111, 4'b0000, 3'b000);
		// three writers on bank 3, pointer walks 0, 1, 2, 0
		add_step("rr3_a", NO_READS, {make_write(11, 32'h0b0b_0001, 2, 1'b1),
			make_write(7, 32'h0707_0001, 1, 1'b1), make_write(3, 32'h0303_0001, 0, 1'b1)},
			4'b0000, 4'b0000, 3'b001);
		add_step("rr3_b", NO_READS, {make_write(11, 32'h0b0b_0002, 2, 1'b1),
			make_write(7, 32'h0707_0002, 1, 1'b1), make_write(15, 32'h0f0f_0002, 4, 1'b0)},
			4'b0000, 4'b0000, 3'b010);
		add_step("rr3_c", NO_READS, {make_write(11, 32'h0b0b_0003, 2, 1'b1),
			make_write(7, 32'h0707_0003, 1, 1'b1), make_write(15, 32'h0f0f_0003, 4, 1'b0)},
			4'b0000, 4'b0000, 3'b100);
		add_step("rr3_d", NO_READS, {make_write(11, 32'h0b0b_0004, 2, 1'b1),
			make_write(7, 32'h0707_0004, 1, 1'b1), make_write(15, 32'h0f0f_0004, 4, 1'b0)},
			4'b0000, 4'b0000, 3'b001);
		// two writers on bank 0, requester 0 idle
		add_step("rr2_a", NO_READS, {make_write(12, 32'h0c0c_0001, 6, 1'b1),
			make_write(8, 32'h0808_0001, 5, 1'b1), NO_WB}, 4'b0000, 4'b0000, 3'b010);
		add_step("rr2_b", NO_READS, {make_write(12, 32'h0c0c_0002, 6, 1'b1),
			make_write(8, 32'h0808_0002, 5, 1'b1), NO_WB}, 4'b0000, 4'b0000, 3'b100);
		add_step("rr2_c", NO_READS, {make_write(12, 32'h0c0c_0003, 6, 1'b1),
			make_write(8, 32'h0808_0003, 5, 1'b1), NO_WB}, 4'b0000, 4'b0000, 3'b010);
		// one writer per bank, all taken
		add_step("wb_three_banks", NO_READS, {make_write(19, 32'h1313_0001, 9, 1'b1),
			make_write(6, 32'h0606_0001, 8, 1'b0), make_write(13, 32'h0d0d_0001, 7, 1'b1)},
			4'b0000, 4'b0000, 3'b111);
		add_step("read_bank3_a", {NO_RD, NO_RD, make_read(7), make_read(3)}, NO_WRITES,
			4'b0011, 4'b0010, 3'b000);
		add_step("read_bank3_b", {NO_RD, NO_RD, make_read(15), make_read(11)}, NO_WRITES,
			4'b0011, 4'b0010, 3'b000);
		add_step("read_bank0", {NO_RD, NO_RD, make_read(12), make_read(8)}, NO_WRITES,
			4'b0011, 4'b0010, 3'b000);
		add_step("read_mixed", {NO_RD, make_read(6), make_read(13), make_read(19)}, NO_WRITES,
			4'b0111, 4'b0000, 3'b000);
		// register 0 stays zero
		add_step("write_r0", NO_READS, {NO_WB, NO_WB, make_write(0, 32'hdead_beef, 1, 1'b1)},
			4'b0000, 4'b0000, 3'b001);
		add_step("read_r0", {NO_RD, NO_RD, NO_RD, make_read(0)}, NO_WRITES,
			4'b0001, 4'b0000, 3'b000);
		// same-cycle read sees the old value, forward bus the new one
		add_step("same_cycle", {NO_RD, NO_RD, NO_RD, make_read(6)},
			{NO_WB, make_write(6, 32'h0606_0002, 10, 1'b1), NO_WB}, 4'b0001, 4'b0000, 3'b010);
		add_step("read_r6_new", {NO_RD, NO_RD, NO_RD, make_read(6)}, NO_WRITES,
			4'b0001, 4'b0000, 3'b000);
	endtask

	// ------------------------------
	// models, reads use contents before this step's writes
	task automatic predict_step(input int n, input prf_pkg::read_req_t [RR-1:0] rd,
			input prf_pkg::wb_req_t [WR-1:0] wb);
		int used [NB];
		int b;
		int idx;
		int win;
		step_rd[n] = rd;
		exp_ack[n] = '0;
		exp_port[n] = '0;
		exp_data[n] = '0;
		exp_rdy[n] = '0;
		exp_wb_bus[n] = '0;
		exp_fwd[n] = '0;
		exp_cmp[n] = '0;
		for (int i = 0; i < NB; i++) begin
			used[i] = 0;
		end
		// two ports per bank, lower requester first
		for (int rr = 0; rr < RR; rr++) begin
			b = int'(rd[rr].pr[LB-1:0]);
			if (rd[rr].valid && used[b] < 2) begin
				exp_ack[n][rr] = 1'b1;
				exp_port[n][rr] = (used[b] == 1);
				exp_data[n][rr] = model_reg[rd[rr].pr];
				used[b] = used[b] + 1;
			end
		end
		// circular search from each bank's pointer
		for (b = 0; b < NB; b++) begin
			win = -1;
			for (int k = 0; k < WR; k++) begin
				idx = (rr_ptr[b] + k) % WR;
				if (win < 0 && wb[idx].valid && int'(wb[idx].pr[LB-1:0]) == b) begin
					win = idx;
				end
			end
			if (win >= 0) begin
				rr_ptr[b] = (win + 1) % WR;
				exp_rdy[n][win] = 1'b1;
				exp_wb_bus[n][b].valid = 1'b1;
				exp_wb_bus[n][b].upper_pr = wb[win].pr[LPR-1:LB];
				exp_fwd[n][b] = wb[win].data;
				exp_cmp[n][b].valid = wb[win].send_complete;
				exp_cmp[n][b].rob_index = wb[win].rob_index;
				if (wb[win].pr != '0) begin
					model_reg[wb[win].pr] = wb[win].data;
				end
			end
		end
	endtask

	task automatic drive_step(input int n);
		prf_pkg::read_req_t [RR-1:0] rd;
		prf_pkg::wb_req_t [WR-1:0] wb;
		logic [31:0] r;
		if (n < tbl_name.size()) begin
			rd = tbl_rd[n];
			wb = tbl_wb[n];
			step_name[n] = tbl_name[n];
		end else begin
			for (int rr = 0; rr < RR; rr++) begin
				r = $random(seed);
				rd[rr].valid = r[0];
				rd[rr].pr = r[8:4];
			end
			for (int w = 0; w < WR; w++) begin
				r = $random(seed);
				wb[w].valid = r[0];
				wb[w].send_complete = r[1];
				wb[w].pr = r[8:4];
				wb[w].rob_index = r[15:12];
				wb[w].data = $random(seed);
			end
			step_name[n] = $sformatf("random_%0d", n);
		end
		predict_step(n, rd, wb);
		// directed steps carry hand-derived ack, port and ready
		if (n < tbl_name.size()) begin
			exp_ack[n] = tbl_ack[n];
			exp_port[n] = tbl_port[n];
			exp_rdy[n] = tbl_rdy[n];
		end
		next_read_req = rd;
		next_wb_req = wb;
	endtask

	// ------------------------------
	// output checks
	task automatic check_idle();
		compare_value("after_reset", "read resp", 64'(0), 64'(last_read_resp));
		compare_value("after_reset", "wb ready", 64'(0), 64'(last_wb_ready));
		for (int b = 0; b < NB; b++) begin
			compare_value("after_reset", "wb bus valid", 64'(0), 64'(last_wb_bus[b].valid));
			compare_value("after_reset", "complete valid", 64'(0),
				64'(last_complete_bus[b].valid));
		end
	endtask

	// ack, ready and buses two falling edges after drive
	task automatic check_response(input int n);
		logic [RR-1:0] got_ack;
		logic [RR-1:0] got_port;
		for (int rr = 0; rr < RR; rr++) begin
			got_ack[rr] = last_read_resp[rr].ack;
			got_port[rr] = last_read_resp[rr].port;
		end
		compare_value(step_name[n], "read ack", 64'(exp_ack[n]), 64'(got_ack));
		compare_value(step_name[n], "read port", 64'(exp_port[n]), 64'(got_port));
		compare_value(step_name[n], "wb ready", 64'(exp_rdy[n]), 64'(last_wb_ready));
		for (int b = 0; b < NB; b++) begin
			compare_value(step_name[n], "wb bus", 64'(exp_wb_bus[n][b]), 64'(last_wb_bus[b]));
			compare_value(step_name[n], "forward data", 64'(exp_fwd[n][b]),
				64'(last_forward_data[b]));
			compare_value(step_name[n], "complete bus", 64'(exp_cmp[n][b]),
				64'(last_complete_bus[b]));
		end
	endtask

	// data one edge after the ack, at the register's bank and granted port
	task automatic check_read_data(input int n);
		int b;
		int p;
		for (int rr = 0; rr < RR; rr++) begin
			if (exp_ack[n][rr]) begin
				b = int'(step_rd[n][rr].pr[LB-1:0]);
				p = int'(exp_port[n][rr]);
				compare_value(step_name[n], $sformatf("read data %0d", rr),
					64'(exp_data[n][rr]), 64'(last_read_data[b][p]));
			end
		end
	endtask

	// ------------------------------
	// watchdog
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge CLK);
		$display("TB FAILED");
		$fatal(1, "watchdog expired after %0d cycles without finishing", limit_cycles);
	end

	initial begin
		int k;
		CLK = 1'b0;
		nRST = 1'b0;
		next_read_req = '0;
		next_wb_req = '0;
		seed = 57;
		for (int i = 0; i < `PRF_PR_COUNT; i++) begin
			model_reg[i] = '0;
		end
		for (int b = 0; b < NB; b++) begin
			rr_ptr[b] = 0;
		end
		build_table();
		total_steps = tbl_name.size() + RAND_STEPS;
		limit_cycles = total_steps + 40;
		repeat (16) @(posedge CLK);
		@(negedge CLK);
		nRST = 1'b1;
		check_idle();
		// three extra edges drain the output pipeline
		for (k = 0; k < total_steps + 3; k++) begin
			if (k >= 2 && k - 2 < total_steps) begin
				check_response(k - 2);
			end
			if (k >= 3) begin
				check_read_data(k - 3);
			end
			if (k < total_steps) begin
				drive_step(k);
			end else begin
				next_read_req = '0;
				next_wb_req = '0;
			end
			@(negedge CLK);
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire
